/* Makefile */
TOOL    = verilator
FLAGS   = --binary --timing --assert -j 0
TOP     = pi_bus_tb
FLIST   = vlog.f
OBJ_DIR = obj_dir
SIM_BIN = sim_$(TOP)
PASS    = ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --assert -f $(FLIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(SIM_BIN)
	@out=$$(./$(OBJ_DIR)/$(SIM_BIN)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(OBJ_DIR)

/* dv/pi_bus_tb.sv */
// Testbench for the PI bus subsystem: directed and random transfers from both clients,
// checked against a reference memory and by concurrent assertions at the client ports.
`timescale 1ns/100ps

module pi_bus_tb;

   import pi_bus_pkg::*;

   localparam int  TOUT       = 40;
   localparam int  RAND_XFERS = 12;   // per master
   localparam int  NUM_XFERS  = 2 + 3 + 2 * RAND_XFERS + 3 + 3 + 2;
   localparam real CLK_PERIOD = 8.0;

   logic        clk;
   logic        rst_n;
   logic [1:0]  cmd_valid, cmd_ready, cmd_write, cmd_lock;
   logic [1:0]  rsp_valid, rsp_ready, rsp_err;
   pi_addr_t    cmd_addr [2];
   pi_data_t    cmd_wdata [2];
   pi_data_t    rsp_rdata [2];

   integer      seed = 32'ha316_69d2;
   int          n_checks = 0;
   int          n_errors = 0;
   int          cyc;
   int          phase = 0;       // directed test in progress
   int          lock_rsps = 0;   // master 0 responses inside the locked pair
   logic [1:0]  pend;            // accepted and response not yet taken
   pi_data_t    held_rdata [2];
   logic [1:0]  held_err;

   pi_addr_t    p_addr [2];      // command in flight per master
   logic [1:0]  p_write;
   pi_data_t    p_wdata [2];
   int          acc_cyc [2] = '{0, 0};
   int          issued [2] = '{0, 0};
   int          taken [2] = '{0, 0};
   pi_data_t    ref_mem [64];
   logic [63:0] known = '0;      // words written since reset

   pi_bus_top #(.TOUT_CYCLES(8'(TOUT)), .WAIT_STATES(2), .MEM_WORDS(64)) DUT (
      .clk(clk), .rst_n(rst_n),
      .cmd_valid_0(cmd_valid[0]), .cmd_ready_0(cmd_ready[0]), .cmd_addr_0(cmd_addr[0]),
      .cmd_write_0(cmd_write[0]), .cmd_wdata_0(cmd_wdata[0]), .cmd_lock_0(cmd_lock[0]),
      .rsp_valid_0(rsp_valid[0]), .rsp_ready_0(rsp_ready[0]), .rsp_rdata_0(rsp_rdata[0]),
      .rsp_err_0(rsp_err[0]),
      .cmd_valid_1(cmd_valid[1]), .cmd_ready_1(cmd_ready[1]), .cmd_addr_1(cmd_addr[1]),
      .cmd_write_1(cmd_write[1]), .cmd_wdata_1(cmd_wdata[1]), .cmd_lock_1(cmd_lock[1]),
      .rsp_valid_1(rsp_valid[1]), .rsp_ready_1(rsp_ready[1]), .rsp_rdata_1(rsp_rdata[1]),
      .rsp_err_1(rsp_err[1])
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // cycle count, pending flags and last-cycle response copies
   always @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         pend <= '0;
         cyc  <= 0;
      end
      else
      begin
         cyc <= cyc + 1;
         for (int i = 0; i < 2; i++)
         begin
            if (cmd_valid[i] && cmd_ready[i])
            begin
               pend[i] <= 1'b1;
            end
            else if (rsp_valid[i] && rsp_ready[i])
            begin
               pend[i] <= 1'b0;
            end
            held_rdata[i] <= rsp_rdata[i];
            held_err[i]   <= rsp_err[i];
         end
      end
   end

   for (genvar g = 0; g < 2; g++)
   begin : g_port_checks
      assert property (@(posedge clk) disable iff (!rst_n) pend[g] |-> !cmd_ready[g])
      else
      begin
         n_errors++;
         $display("** Error at %0t: cmd_ready_%0d expected 0 got 1 (response pending)",
                  $time, g);
      end
      assert property (@(posedge clk) disable iff (!rst_n)
                       (rsp_valid[g] && !rsp_ready[g]) |=> rsp_valid[g])
      else
      begin
         n_errors++;
         $display("** Error at %0t: rsp_valid_%0d expected 1 got 0 (response not taken)",
                  $time, g);
      end
      assert property (@(posedge clk) disable iff (!rst_n)
                       (rsp_valid[g] && !rsp_ready[g]) |=> rsp_rdata[g] == held_rdata[g])
      else
      begin
         n_errors++;
         $display("** Error at %0t: rsp_rdata_%0d expected %h got %h", $time, g,
                  $sampled(held_rdata[g]), $sampled(rsp_rdata[g]));
      end
      assert property (@(posedge clk) disable iff (!rst_n)
                       (rsp_valid[g] && !rsp_ready[g]) |=> rsp_err[g] == held_err[g])
      else
      begin
         n_errors++;
         $display("** Error at %0t: rsp_err_%0d expected %b got %b", $time, g,
                  $sampled(held_err[g]), $sampled(rsp_err[g]));
      end
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      n_checks++;
      assert (got === exp)
      else
      begin
         n_errors++;
         $display("** Error at %0t: %s expected %h got %h", $time, name, exp, got);
      end
   endtask

   // expected response from the address map and the reference memory
   task automatic check_rsp(input int m);
      logic [5:0] idx;
      logic       in_region;
      logic       exp_err;
      idx       = p_addr[m][5:0];
      in_region = (p_addr[m][29:28] == 2'b11);
      exp_err   = !in_region || ((idx == 6'd0) && p_write[m]);
      check_value($sformatf("rsp_err_%0d", m), 32'(rsp_err[m]), 32'(exp_err));
      if (!exp_err && p_write[m])
      begin
         ref_mem[idx] = p_wdata[m];
         known[idx]   = 1'b1;
      end
      else if (!exp_err && ((idx == 6'd0) || known[idx]))
      begin
         check_value($sformatf("rsp_rdata_%0d", m), rsp_rdata[m],
                     (idx == 6'd0) ? PI_ID_WORD : ref_mem[idx]);
      end
      if (!in_region)
      begin
         n_checks++;
         assert (cyc - acc_cyc[m] >= TOUT)
         else
         begin
            n_errors++;
            $display("** Error at %0t: rsp_valid_%0d latency expected >= %0d got %0d",
                     $time, m, TOUT, cyc - acc_cyc[m]);
         end
      end
      if ((phase == 5) && (m == 0))
      begin
         lock_rsps++;
      end
      else if (phase == 5)
      begin
         n_checks++;
         assert (lock_rsps == 2)
         else
         begin
            n_errors++;
            $display("Master 1 was served inside the locked pair of master 0 at %0t", $time);
         end
      end
   endtask

   // handshakes seen mid-cycle, where all port values are settled
   always @(negedge clk)
   begin
      if (rst_n)
      begin
         for (int i = 0; i < 2; i++)
         begin
            if (rsp_valid[i] && rsp_ready[i])
            begin
               check_rsp(i);
               taken[i]++;
            end
            if (cmd_valid[i] && cmd_ready[i])
            begin
               p_addr[i]  = cmd_addr[i];
               p_write[i] = cmd_write[i];
               p_wdata[i] = cmd_wdata[i];
               acc_cyc[i] = cyc;
               issued[i]++;
            end
         end
      end
   end

   task automatic send_cmd(input int m, input pi_addr_t a, input logic wr,
                           input pi_data_t d, input logic lk);
      @(posedge clk);
      #1;
      cmd_valid[m] = 1'b1;
      cmd_addr[m]  = a;
      cmd_write[m] = wr;
      cmd_wdata[m] = d;
      cmd_lock[m]  = lk;
      do
         @(negedge clk);
      while (!cmd_ready[m]);
      @(posedge clk);
      #1;
      cmd_valid[m] = 1'b0;
   endtask

   task automatic wait_rsp(input int m);
      do
         @(negedge clk);
      while (!(rsp_valid[m] && rsp_ready[m]));
      @(posedge clk);
   endtask

   task automatic run_xfer(input int m, input pi_addr_t a, input logic wr,
                           input pi_data_t d, input logic lk);
      send_cmd(m, a, wr, d, lk);
      wait_rsp(m);
   endtask

   task automatic random_traffic(input int m, input int n);
      logic [31:0] r;
      logic [31:0] d;
      for (int i = 0; i < n; i++)
      begin
         r = $random(seed);
         d = $random(seed);
         run_xfer(m, {2'b11, 24'd0, r[3:0]}, r[8], d, 1'b0);   // 16 words so reads often hit
         repeat (r[10:9]) @(posedge clk);
      end
   endtask

   initial
   begin
      pi_data_t d;
      cmd_valid = '0;
      cmd_write = '0;
      cmd_lock  = '0;
      rsp_ready = 2'b11;
      for (int i = 0; i < 2; i++)
      begin
         cmd_addr[i]  = '0;
         cmd_wdata[i] = '0;
      end
      rst_n = 1'b0;
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;

      phase = 1;
      d     = $random(seed);
      run_xfer(0, {2'b11, 28'h15}, 1'b1, d, 1'b0);
      run_xfer(0, {2'b11, 28'h15}, 1'b0, '0, 1'b0);

      phase = 2;   // identification word
      run_xfer(0, {2'b11, 28'h0}, 1'b0, '0, 1'b0);
      run_xfer(0, {2'b11, 28'h0}, 1'b1, d, 1'b0);
      run_xfer(1, {2'b11, 28'h0}, 1'b0, '0, 1'b0);

      phase = 3;
      fork
         random_traffic(0, RAND_XFERS);
         random_traffic(1, RAND_XFERS);
      join

      phase = 4;   // nobody answers outside the select region
      d     = $random(seed);
      fork
         run_xfer(0, 30'h0000_0123, 1'b0, '0, 1'b0);
         begin
            repeat (3) @(posedge clk);
            run_xfer(1, {2'b11, 28'h2a}, 1'b1, d, 1'b0);
            run_xfer(1, {2'b11, 28'h2a}, 1'b0, '0, 1'b0);
         end
      join

      phase = 5;
      fork
         begin
            run_xfer(0, {2'b11, 28'h07}, 1'b1, d, 1'b1);
            run_xfer(0, {2'b11, 28'h07}, 1'b0, '0, 1'b0);
         end
         begin
            repeat (4) @(posedge clk);
            run_xfer(1, {2'b11, 28'h09}, 1'b1, ~d, 1'b0);
         end
      join

      phase = 6;   // client back-pressure on the response
      d     = $random(seed);
      run_xfer(0, {2'b11, 28'h31}, 1'b1, d, 1'b0);
      #1;
      rsp_ready[0] = 1'b0;
      send_cmd(0, {2'b11, 28'h31}, 1'b0, '0, 1'b0);
      do
         @(negedge clk);
      while (!rsp_valid[0]);
      repeat (5) @(posedge clk);
      #1;
      rsp_ready[0] = 1'b1;
      wait_rsp(0);

      repeat (2) @(posedge clk);
      for (int i = 0; i < 2; i++)
      begin
         check_value($sformatf("responses_%0d", i), 32'(taken[i]), 32'(issued[i]));
      end
      $display("checks %0d, errors %0d", n_checks, n_errors);
      if (n_errors == 0)
      begin
         $display("ALL CHECKS PASSED");
      end
      else
      begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

   // every transfer may take up to one full bus timeout
   initial
   begin
      #((NUM_XFERS * (TOUT + 20) + 10) * CLK_PERIOD);
      $display("Watchdog expired before all transfers completed");
      $display("checks %0d, errors %0d", n_checks, n_errors);
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

/* hdl/pi_bus_cont.sv */
// PI bus controller: round-robin arbitration of two masters with lock, one-cycle grant,
// slave select decode, address/data phase tracking and bus timeout.
`timescale 1ns/100ps

module pi_bus_cont #(
   parameter logic [7:0] TOUT_CYCLES = 8'd255
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 req_0,
   input  logic                 req_1,
   input  logic                 lock,
   input  pi_bus_pkg::pi_addr_t addr,
   input  pi_bus_pkg::pi_opc_t  opc,
   input  pi_bus_pkg::pi_ack_t  ack,
   output logic                 gnt_0,
   output logic                 gnt_1,
   output logic                 sel,
   output logic                 tout
);

   import pi_bus_pkg::*;

   pi_bus_state_e state;
   logic          owner;       // last granted master, 0 or 1
   logic          lock_hold;   // next grant reserved for owner
   logic [7:0]    tout_cnt;
   logic          in_phase;
   logic          counting;
   logic          xfer_end;
   logic          tout_hit;
   logic          hold_now;
   logic          own_req;
   logic          oth_req;
   logic          nxt_valid;
   logic          nxt_owner;
   logic          grant_now;

   assign in_phase = (state == BUS_ADDR) || (state == BUS_ADDRDATA) || (state == BUS_DATA);
   assign counting = (state == BUS_ADDRDATA) || (state == BUS_DATA);

   // memory slave lives at the top quarter of the address space
   assign sel = in_phase && (addr[29:28] == 2'b11) && (opc != PI_OPC_NOP);

   // RDY and ERR both close the transfer, RDY beats a timeout in the same cycle
   assign xfer_end = in_phase && ((ack == PI_ACK_RDY) || (ack == PI_ACK_ERR));
   assign tout_hit = counting && !xfer_end && (tout_cnt == TOUT_CYCLES - 8'd1);

   assign own_req  = owner ? req_1 : req_0;
   assign oth_req  = owner ? req_0 : req_1;
   assign hold_now = in_phase ? lock : lock_hold;   // live lock at the end of a transfer

   // pick the next owner, the other master first unless the bus is locked
   always_comb
   begin
      nxt_valid = 1'b0;
      nxt_owner = owner;
      if (hold_now)
      begin
         nxt_valid = own_req;   // other requester keeps waiting
      end
      else if (oth_req)
      begin
         nxt_valid = 1'b1;
         nxt_owner = ~owner;
      end
      else if (own_req)
      begin
         nxt_valid = 1'b1;
      end
   end

   assign grant_now = nxt_valid && ((state == BUS_IDLE) || xfer_end);

   // grant and timeout strobes, one cycle each
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         gnt_0 <= 1'b0;
         gnt_1 <= 1'b0;
         tout  <= 1'b0;
         owner <= 1'b1;   // master 0 wins the first round
      end
      else
      begin
         gnt_0 <= grant_now && !nxt_owner;
         gnt_1 <= grant_now && nxt_owner;
         tout  <= tout_hit;
         if (grant_now)
         begin
            owner <= nxt_owner;
         end
      end
   end

   // phase machine and timeout counter
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state     <= BUS_IDLE;
         lock_hold <= 1'b0;
         tout_cnt  <= '0;
      end
      else
      begin
         case (state)
            BUS_IDLE:
            begin
               tout_cnt <= '0;
               if (grant_now)
               begin
                  state <= BUS_REQ;
               end
            end
            BUS_REQ:
            begin
               state <= BUS_ADDR;   // owner puts the address out next
            end
            BUS_ADDR, BUS_ADDRDATA, BUS_DATA:
            begin
               if (xfer_end)
               begin
                  lock_hold <= lock;
                  tout_cnt  <= '0;
                  state     <= grant_now ? BUS_REQ : BUS_IDLE;
               end
               else if (tout_hit)
               begin
                  // nobody answered, drop the owner and any reservation
                  lock_hold <= 1'b0;
                  tout_cnt  <= '0;
                  state     <= BUS_IDLE;
               end
               else
               begin
                  if (counting)
                  begin
                     tout_cnt <= tout_cnt + 8'd1;
                  end
                  if ((ack == PI_ACK_WAT) || (state == BUS_DATA))
                  begin
                     state <= BUS_DATA;
                  end
                  else
                  begin
                     state <= BUS_ADDRDATA;   // no answer yet
                  end
               end
            end
            default:
            begin
               state <= BUS_IDLE;
            end
         endcase
      end
   end

endmodule

/* hdl/pi_bus_pkg.sv */
// Shared widths, opcodes, acknowledge codes and controller states for the PI bus.
// Modules import it inside their body and use scoped names in their port lists.

package pi_bus_pkg;

   // word address, top two bits 11 select the memory slave
   typedef logic [29:0] pi_addr_t;

   typedef logic [31:0] pi_data_t;   // one bus word
   typedef logic [3:0]  pi_opc_t;    // transfer opcode
   typedef logic [2:0]  pi_ack_t;    // slave acknowledge

   // opcodes
   localparam pi_opc_t PI_OPC_NOP  = 4'd0;   // nothing on the bus
   localparam pi_opc_t PI_OPC_WORD = 4'd1;   // single word transfer

   // acknowledge codes, one hot apart from IDLE
   localparam pi_ack_t PI_ACK_IDLE = 3'b000;   // no answer
   localparam pi_ack_t PI_ACK_RDY  = 3'b001;
   localparam pi_ack_t PI_ACK_WAT  = 3'b010;
   localparam pi_ack_t PI_ACK_ERR  = 3'b100;

   // bus controller phases
   typedef enum logic [2:0]
   {
      BUS_IDLE,
      BUS_REQ,        // grant cycle
      BUS_ADDR,       // owner drives address and opcode
      BUS_ADDRDATA,   // still waiting for a first answer
      BUS_DATA        // slave inserts wait states
   } pi_bus_state_e;

   // read-only contents of slave word zero
   localparam pi_data_t PI_ID_WORD = 32'h5049_4431;

endpackage

/* hdl/pi_bus_top.sv */
// PI bus subsystem top: two client-facing masters, the bus controller and one memory
// slave. Master outputs are zero when idle and are ORed onto the shared bus.
`timescale 1ns/100ps

module pi_bus_top #(
   parameter logic [7:0] TOUT_CYCLES = 8'd255,
   parameter int         WAIT_STATES = 2,
   parameter int         MEM_WORDS   = 64
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 cmd_valid_0,
   output logic                 cmd_ready_0,
   input  pi_bus_pkg::pi_addr_t cmd_addr_0,
   input  logic                 cmd_write_0,
   input  pi_bus_pkg::pi_data_t cmd_wdata_0,
   input  logic                 cmd_lock_0,
   output logic                 rsp_valid_0,
   input  logic                 rsp_ready_0,
   output pi_bus_pkg::pi_data_t rsp_rdata_0,
   output logic                 rsp_err_0,
   input  logic                 cmd_valid_1,
   output logic                 cmd_ready_1,
   input  pi_bus_pkg::pi_addr_t cmd_addr_1,
   input  logic                 cmd_write_1,
   input  pi_bus_pkg::pi_data_t cmd_wdata_1,
   input  logic                 cmd_lock_1,
   output logic                 rsp_valid_1,
   input  logic                 rsp_ready_1,
   output pi_bus_pkg::pi_data_t rsp_rdata_1,
   output logic                 rsp_err_1
);

   import pi_bus_pkg::*;

   logic     req_0, req_1, gnt_0, gnt_1;
   logic     lock_0, lock_1, read_0, read_1;
   pi_addr_t addr_0, addr_1;
   pi_opc_t  opc_0, opc_1;
   pi_data_t wdata_0, wdata_1;
   logic     bus_lock, bus_read, sel, tout;
   pi_addr_t bus_addr;
   pi_opc_t  bus_opc;
   pi_data_t bus_wdata, rdata;
   pi_ack_t  ack;

   // shared bus, only the owner drives non-zero values
   assign bus_lock  = lock_0 | lock_1;
   assign bus_read  = read_0 | read_1;
   assign bus_addr  = addr_0 | addr_1;
   assign bus_opc   = opc_0 | opc_1;
   assign bus_wdata = wdata_0 | wdata_1;

   pi_master u_master_0 (
      .clk(clk), .rst_n(rst_n),
      .cmd_valid(cmd_valid_0), .cmd_ready(cmd_ready_0), .cmd_addr(cmd_addr_0),
      .cmd_write(cmd_write_0), .cmd_wdata(cmd_wdata_0), .cmd_lock(cmd_lock_0),
      .rsp_valid(rsp_valid_0), .rsp_ready(rsp_ready_0), .rsp_rdata(rsp_rdata_0),
      .rsp_err(rsp_err_0), .req(req_0), .lock(lock_0), .addr(addr_0), .opc(opc_0),
      .read(read_0), .wdata(wdata_0), .gnt(gnt_0), .ack(ack), .rdata(rdata), .tout(tout)
   );

   pi_master u_master_1 (
      .clk(clk), .rst_n(rst_n),
      .cmd_valid(cmd_valid_1), .cmd_ready(cmd_ready_1), .cmd_addr(cmd_addr_1),
      .cmd_write(cmd_write_1), .cmd_wdata(cmd_wdata_1), .cmd_lock(cmd_lock_1),
      .rsp_valid(rsp_valid_1), .rsp_ready(rsp_ready_1), .rsp_rdata(rsp_rdata_1),
      .rsp_err(rsp_err_1), .req(req_1), .lock(lock_1), .addr(addr_1), .opc(opc_1),
      .read(read_1), .wdata(wdata_1), .gnt(gnt_1), .ack(ack), .rdata(rdata), .tout(tout)
   );

   pi_bus_cont #(.TOUT_CYCLES(TOUT_CYCLES)) u_bus_cont (
      .clk(clk), .rst_n(rst_n), .req_0(req_0), .req_1(req_1), .lock(bus_lock),
      .addr(bus_addr), .opc(bus_opc), .ack(ack),
      .gnt_0(gnt_0), .gnt_1(gnt_1), .sel(sel), .tout(tout)
   );

   pi_mem_slave #(.WAIT_STATES(WAIT_STATES), .MEM_WORDS(MEM_WORDS)) u_mem_slave (
      .clk(clk), .rst_n(rst_n), .sel(sel), .addr(bus_addr), .opc(bus_opc),
      .read(bus_read), .wdata(bus_wdata), .ack(ack), .rdata(rdata)
   );

endmodule

/* hdl/pi_master.sv */
// PI bus master: takes one word command from a valid/ready client, requests the bus,
// runs the transfer and holds the response until the client takes it.
`timescale 1ns/100ps

module pi_master (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 cmd_valid,
   output logic                 cmd_ready,
   input  pi_bus_pkg::pi_addr_t cmd_addr,
   input  logic                 cmd_write,
   input  pi_bus_pkg::pi_data_t cmd_wdata,
   input  logic                 cmd_lock,
   output logic                 rsp_valid,
   input  logic                 rsp_ready,
   output pi_bus_pkg::pi_data_t rsp_rdata,
   output logic                 rsp_err,
   output logic                 req,
   output logic                 lock,
   output pi_bus_pkg::pi_addr_t addr,
   output pi_bus_pkg::pi_opc_t  opc,
   output logic                 read,
   output pi_bus_pkg::pi_data_t wdata,
   input  logic                 gnt,
   input  pi_bus_pkg::pi_ack_t  ack,
   input  pi_bus_pkg::pi_data_t rdata,
   input  logic                 tout
);

   import pi_bus_pkg::*;

   typedef enum logic [1:0]
   {
      M_IDLE,   // waiting for a command
      M_REQ,    // requesting the bus
      M_OWN,    // driving the transfer
      M_RSP     // response waiting for the client
   } mst_state_e;

   mst_state_e state;
   pi_addr_t   addr_q;
   logic       write_q;
   pi_data_t   wdata_q;
   logic       lock_q;
   logic       owner;
   logic       fail;
   logic       done;
   logic       cmd_take;

   assign cmd_take = cmd_valid && cmd_ready;
   assign owner    = (state == M_OWN);
   assign fail     = (ack == PI_ACK_ERR) || tout;
   assign done     = owner && ((ack == PI_ACK_RDY) || fail);

   assign req       = (state == M_REQ);
   assign rsp_valid = (state == M_RSP);

   // bus outputs are zero when not owner so the top level can OR them
   assign lock  = owner && lock_q;
   assign addr  = owner ? addr_q : '0;
   assign opc   = owner ? PI_OPC_WORD : PI_OPC_NOP;
   assign read  = owner && !write_q;
   assign wdata = owner ? wdata_q : '0;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state     <= M_IDLE;
         cmd_ready <= 1'b0;
      end
      else
      begin
         case (state)
            M_IDLE:
            begin
               if (cmd_take)
               begin
                  state     <= M_REQ;
                  cmd_ready <= 1'b0;
               end
               else
               begin
                  cmd_ready <= 1'b1;
               end
            end
            M_REQ:
            begin
               if (gnt)
               begin
                  state <= M_OWN;
               end
            end
            M_OWN:
            begin
               if (done)
               begin
                  state <= M_RSP;
               end
            end
            M_RSP:
            begin
               if (rsp_ready)
               begin
                  state     <= M_IDLE;
                  cmd_ready <= 1'b1;   // ready for the next command
               end
            end
            default:
            begin
               state <= M_IDLE;
            end
         endcase
      end
   end

   // command and response payload
   always_ff @(posedge clk)
   begin
      if (cmd_take)
      begin
         addr_q  <= cmd_addr;
         write_q <= cmd_write;
         wdata_q <= cmd_wdata;
         lock_q  <= cmd_lock;
      end
      if (done)
      begin
         rsp_rdata <= (write_q || fail) ? '0 : rdata;   // data only on good reads
         rsp_err   <= fail;
      end
   end

endmodule

/* hdl/pi_mem_slave.sv */
// Word memory slave on the PI bus. Answers WAT for WAIT_STATES cycles after select,
// then RDY, or ERR for a bad opcode or a write to the read-only identification word.
`timescale 1ns/100ps

module pi_mem_slave #(
   parameter int WAIT_STATES = 2,
   parameter int MEM_WORDS   = 64
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 sel,
   input  pi_bus_pkg::pi_addr_t addr,
   input  pi_bus_pkg::pi_opc_t  opc,
   input  logic                 read,
   input  pi_bus_pkg::pi_data_t wdata,
   output pi_bus_pkg::pi_ack_t  ack,
   output pi_bus_pkg::pi_data_t rdata
);

   import pi_bus_pkg::*;

   // MEM_WORDS is expected to be a power of two
   localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
   localparam int CNT_W = $clog2(WAIT_STATES + 1) + 1;

   pi_data_t         mem [MEM_WORDS];
   logic             busy;       // transfer seen, waiting for sel to drop
   logic [CNT_W-1:0] wait_cnt;   // wait states issued so far
   logic [IDX_W-1:0] idx;
   logic             is_id;
   logic             bad;
   logic             access;
   pi_ack_t          resp;

   assign idx   = addr[IDX_W-1:0];
   assign is_id = (idx == '0);
   assign bad   = (opc != PI_OPC_WORD) || (is_id && !read);
   assign resp  = bad ? PI_ACK_ERR : PI_ACK_RDY;

   // the edge that registers the final answer also does the memory access
   assign access = sel && (busy ? ((ack == PI_ACK_WAT) && (wait_cnt == CNT_W'(WAIT_STATES)))
                                : (WAIT_STATES == 0));

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         busy     <= 1'b0;
         wait_cnt <= '0;
         ack      <= PI_ACK_IDLE;
      end
      else if (!sel)
      begin
         busy <= 1'b0;
         ack  <= PI_ACK_IDLE;
      end
      else if (!busy)
      begin
         busy     <= 1'b1;
         wait_cnt <= CNT_W'(1);
         ack      <= access ? resp : PI_ACK_WAT;
      end
      else if (access)
      begin
         ack <= resp;
      end
      else if (ack == PI_ACK_WAT)
      begin
         wait_cnt <= wait_cnt + CNT_W'(1);   // one more wait state
      end
      else
      begin
         ack <= PI_ACK_IDLE;   // answered once, hold off until deselect
      end
   end

   always_ff @(posedge clk)
   begin
      if (access)
      begin
         if (read)
         begin
            rdata <= is_id ? PI_ID_WORD : mem[idx];
         end
         else if (!bad)
         begin
            mem[idx] <= wdata;
         end
      end
   end

endmodule

/* vlog.f */
hdl/pi_bus_pkg.sv
hdl/pi_bus_cont.sv
hdl/pi_master.sv
hdl/pi_mem_slave.sv
hdl/pi_bus_top.sv
dv/pi_bus_tb.sv
